/* source/framer_pkg.sv */
package framer_pkg;

   // One complex sample
   typedef struct packed {
      logic signed [15:0] i;
      logic signed [15:0] q;
   } sample_t;

   typedef struct packed {
      logic hit;   // Rising threshold crossing
   } trig_t;

   typedef struct packed {
      logic [15:0] frame_len;
      logic [15:0] gap_len;
      logic [15:0] offset;
      logic [15:0] max_frames;   // 0 runs forever
      logic [16:0] threshold;    // Compared with |I| + |Q|
      logic        pair_first;
      logic        enable;
   } framer_cfg_t;

   typedef struct packed {
      logic [31:0] frames_sent;
      logic        overflow;
   } framer_status_t;

   // Byte addresses on the AXI4-Lite bus
   localparam logic [7:0] reg_ctrl        = 8'h00;
   localparam logic [7:0] reg_frame_len   = 8'h04;
   localparam logic [7:0] reg_gap_len     = 8'h08;
   localparam logic [7:0] reg_offset      = 8'h0C;
   localparam logic [7:0] reg_max_frames  = 8'h10;
   localparam logic [7:0] reg_threshold   = 8'h14;
   localparam logic [7:0] reg_frames_sent = 8'h18;
   localparam logic [7:0] reg_status      = 8'h1C;

   // Control register bits
   localparam int ctrl_enable_bit     = 0;
   localparam int ctrl_pair_first_bit = 1;
   localparam int ctrl_soft_clear_bit = 31;

endpackage

/* source/framer_regs.sv */
`timescale 1ns/1ps

module framer_regs
(
   input  logic                      clk,
   input  logic                      arst_n,
   // AXI4-Lite slave
   input  logic [7:0]                awaddr,
   input  logic                      awvalid,
   output logic                      awready,
   input  logic [31:0]               wdata,
   input  logic [3:0]                wstrb,
   input  logic                      wvalid,
   output logic                      wready,
   output logic [1:0]                bresp,
   output logic                      bvalid,
   input  logic                      bready,
   input  logic [7:0]                araddr,
   input  logic                      arvalid,
   output logic                      arready,
   output logic [31:0]               rdata,
   output logic [1:0]                rresp,
   output logic                      rvalid,
   input  logic                      rready,
   // Design side
   input  logic                      frame_done,
   input  logic [1:0]                overflow,
   output framer_pkg::framer_cfg_t   cfg,
   output logic                      soft_clear
);

   framer_pkg::framer_cfg_t    cfg_q;
   framer_pkg::framer_status_t status_q;
   logic                       wr_accept;
   logic                       rd_accept;
   logic [31:0]                wr_word;

   // Register image as software sees it, zero for unknown addresses
   function automatic logic [31:0] reg_read(input logic [7:0]                 addr,
                                            input framer_pkg::framer_cfg_t    c,
                                            input framer_pkg::framer_status_t s);
      logic [31:0] v;
      v = '0;
      case (addr)
         framer_pkg::reg_ctrl:
         begin
            v[framer_pkg::ctrl_enable_bit]     = c.enable;
            v[framer_pkg::ctrl_pair_first_bit] = c.pair_first;
         end
         framer_pkg::reg_frame_len:   v[15:0] = c.frame_len;
         framer_pkg::reg_gap_len:     v[15:0] = c.gap_len;
         framer_pkg::reg_offset:      v[15:0] = c.offset;
         framer_pkg::reg_max_frames:  v[15:0] = c.max_frames;
         framer_pkg::reg_threshold:   v[16:0] = c.threshold;
         framer_pkg::reg_frames_sent: v       = s.frames_sent;
         framer_pkg::reg_status:      v[0]    = s.overflow;
         default:                     v       = '0;
      endcase
      return v;
   endfunction

   assign wr_accept = awvalid & wvalid & ~bvalid;
   assign rd_accept = arvalid & ~rvalid;
   assign awready   = wr_accept;
   assign wready    = wr_accept;
   assign arready   = rd_accept;
   assign bresp     = 2'b00;   // OKAY
   assign rresp     = 2'b00;
   assign cfg       = cfg_q;

   // Byte lanes not strobed keep their old value
   always_comb
   begin
      wr_word = reg_read(awaddr, cfg_q, status_q);
      for (int b = 0; b < 4; b++)
      begin
         if (wstrb[b])
            wr_word[8*b +: 8] = wdata[8*b +: 8];
      end
   end

   always_ff @(posedge clk or negedge arst_n)
   begin
      if (!arst_n)
      begin
         cfg_q      <= '0;
         soft_clear <= 1'b0;
         bvalid     <= 1'b0;
      end
      else
      begin
         soft_clear <= 1'b0;
         if (wr_accept)
         begin
            bvalid <= 1'b1;
            case (awaddr)
               framer_pkg::reg_ctrl:
               begin
                  cfg_q.enable     <= wr_word[framer_pkg::ctrl_enable_bit];
                  cfg_q.pair_first <= wr_word[framer_pkg::ctrl_pair_first_bit];
                  soft_clear       <= wr_word[framer_pkg::ctrl_soft_clear_bit];
               end
               framer_pkg::reg_frame_len:  cfg_q.frame_len  <= wr_word[15:0];
               framer_pkg::reg_gap_len:    cfg_q.gap_len    <= wr_word[15:0];
               framer_pkg::reg_offset:     cfg_q.offset     <= wr_word[15:0];
               framer_pkg::reg_max_frames: cfg_q.max_frames <= wr_word[15:0];
               framer_pkg::reg_threshold:  cfg_q.threshold  <= wr_word[16:0];
               default: ;   // Read-only or unmapped
            endcase
         end
         else if (bready)
            bvalid <= 1'b0;
      end
   end

   // Status counters
   always_ff @(posedge clk or negedge arst_n)
   begin
      if (!arst_n)
         status_q <= '0;
      else if (soft_clear)
         status_q <= '0;
      else
      begin
         if (frame_done)
            status_q.frames_sent <= status_q.frames_sent + 32'd1;
         if (|overflow)
            status_q.overflow <= 1'b1;   // Sticky until soft clear
      end
   end

   always_ff @(posedge clk or negedge arst_n)
   begin
      if (!arst_n)
         rvalid <= 1'b0;
      else if (rd_accept)
         rvalid <= 1'b1;
      else if (rready)
         rvalid <= 1'b0;
   end

   always_ff @(posedge clk)
   begin
      if (rd_accept)
         rdata <= reg_read(araddr, cfg_q, status_q);
   end

   // A write response needs a handshake in the cycle before
   a_bvalid_after_write: assert property (@(posedge clk) disable iff (!arst_n)
      $rose(bvalid) |-> $past(wr_accept));

endmodule

/* source/power_trigger.sv */
`timescale 1ns/1ps

module power_trigger
(
   input  logic                    clk,
   input  logic                    arst_n,
   input  logic                    soft_clear,
   input  framer_pkg::framer_cfg_t cfg,
   input  logic                    in_valid,
   input  framer_pkg::sample_t     in_data,
   output logic                    push,
   output framer_pkg::trig_t       trig,
   output framer_pkg::sample_t     sample
);

   logic [15:0] abs_i;
   logic [15:0] abs_q;
   logic [16:0] mag;
   logic        above;
   logic        prev_above;   // Previous valid sample was over threshold

   // -32768 maps to 16'h8000, still correct as unsigned
   assign abs_i = in_data.i[15] ? 16'(-in_data.i) : 16'(in_data.i);
   assign abs_q = in_data.q[15] ? 16'(-in_data.q) : 16'(in_data.q);
   assign mag   = {1'b0, abs_i} + {1'b0, abs_q};
   assign above = mag >= cfg.threshold;

   always_ff @(posedge clk or negedge arst_n)
   begin
      if (!arst_n)
      begin
         push       <= 1'b0;
         trig       <= '0;
         prev_above <= 1'b0;
      end
      else
      begin
         push     <= in_valid;
         trig.hit <= in_valid & above & ~prev_above;
         if (soft_clear)
            prev_above <= 1'b0;
         else if (in_valid)
            prev_above <= above;
      end
   end

   // Sample rides along so both FIFOs see the same push
   always_ff @(posedge clk)
   begin
      if (in_valid)
         sample <= in_data;
   end

endmodule

/* source/stream_fifo.sv */
`timescale 1ns/1ps

module stream_fifo
#(
   parameter type payload_t = logic,
   parameter int  DEPTH     = 16
)
(
   input  logic     clk,
   input  logic     arst_n,
   input  logic     soft_clear,
   input  logic     push,
   input  payload_t push_data,
   input  logic     pop,
   output payload_t head,
   output logic     head_valid,
   output logic     overflow
);

   localparam int AW = (DEPTH > 1) ? $clog2(DEPTH) : 1;

   payload_t      mem [DEPTH];
   logic [AW-1:0] wr_ptr;
   logic [AW-1:0] rd_ptr;
   logic [AW:0]   count;
   logic          full;
   logic          do_push;
   logic          do_pop;

   assign full       = count == (AW + 1)'(DEPTH);
   assign head_valid = count != '0;
   assign head       = mem[rd_ptr];
   assign do_pop     = pop & head_valid;
   assign do_push    = push & (~full | do_pop);   // Full drops unless a slot frees

   always_ff @(posedge clk or negedge arst_n)
   begin
      if (!arst_n)
      begin
         wr_ptr   <= '0;
         rd_ptr   <= '0;
         count    <= '0;
         overflow <= 1'b0;
      end
      else if (soft_clear)
      begin
         wr_ptr   <= '0;
         rd_ptr   <= '0;
         count    <= '0;
         overflow <= 1'b0;
      end
      else
      begin
         overflow <= push & ~do_push;   // One pulse per lost entry
         if (do_push)
            wr_ptr <= (wr_ptr == AW'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
         if (do_pop)
            rd_ptr <= (rd_ptr == AW'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
         count <= count + (AW + 1)'(do_push) - (AW + 1)'(do_pop);
      end
   end

   always_ff @(posedge clk)
   begin
      if (do_push)
         mem[wr_ptr] <= push_data;
   end

   a_pop_needs_head: assert property (@(posedge clk) disable iff (!arst_n)
      pop |-> head_valid);
   a_count_bound: assert property (@(posedge clk) disable iff (!arst_n)
      count <= (AW + 1)'(DEPTH));

endmodule

/* source/periodic_framer.sv */
`timescale 1ns/1ps

module periodic_framer
(
   input  logic                    clk,
   input  logic                    arst_n,
   input  logic                    soft_clear,
   input  framer_pkg::framer_cfg_t cfg,
   // FIFO heads
   input  framer_pkg::sample_t     sample_head,
   input  logic                    sample_valid,
   input  framer_pkg::trig_t       trig_head,
   input  logic                    trig_valid,
   output logic                    pop,
   // Output stream
   output framer_pkg::sample_t     out_data,
   output logic                    out_last,
   output logic                    out_valid,
   input  logic                    out_ready,
   output logic                    eob,
   output logic                    frame_done
);

   typedef enum logic [1:0] {
      st_wait,
      st_offset,
      st_frame,
      st_gap
   } state_t;

   state_t      state;
   logic [15:0] counter;       // Beats into the current phase, from 1
   logic [15:0] frame_cnt;     // Frames sent in this burst
   logic        first_frame;
   logic        both_valid;
   logic        consume;
   logic        burst_end;

   assign both_valid = sample_valid & trig_valid;
   assign consume    = both_valid & ((state != st_frame) | out_ready);
   assign pop        = consume;

   assign burst_end  = (cfg.max_frames != 16'd0) &&
                       (frame_cnt >= cfg.max_frames - 16'd1);

   assign out_data   = sample_head;
   assign out_valid  = both_valid & (state == st_frame);
   assign out_last   = (state == st_frame) & (counter >= cfg.frame_len);
   assign eob        = out_valid & out_last & burst_end;
   assign frame_done = consume & out_last;

   always_ff @(posedge clk or negedge arst_n)
   begin
      if (!arst_n)
      begin
         state       <= st_wait;
         counter     <= '0;
         frame_cnt   <= '0;
         first_frame <= 1'b0;
      end
      else if (soft_clear)
      begin
         state       <= st_wait;
         counter     <= '0;
         frame_cnt   <= '0;
         first_frame <= 1'b0;
      end
      else if (consume)
      begin
         case (state)
            st_wait:
            begin
               if (trig_head.hit && cfg.enable)
               begin
                  state   <= st_offset;
                  counter <= 16'd1;
               end
            end
            st_offset:
            begin
               if (counter >= cfg.offset)
               begin
                  state       <= st_frame;
                  counter     <= 16'd1;
                  first_frame <= 1'b1;
                  frame_cnt   <= '0;
               end
               else
                  counter <= counter + 16'd1;
            end
            st_frame:
            begin
               if (out_last)
               begin
                  counter     <= 16'd1;
                  first_frame <= 1'b0;
                  frame_cnt   <= frame_cnt + 16'd1;
                  if (burst_end)
                     state <= st_wait;
                  else if (!(first_frame && cfg.pair_first))
                     state <= st_gap;   // Paired frames skip the gap
               end
               else
                  counter <= counter + 16'd1;
            end
            default:   // st_gap
            begin
               if (counter >= cfg.gap_len)
               begin
                  state   <= st_frame;
                  counter <= 16'd1;
               end
               else
                  counter <= counter + 16'd1;
            end
         endcase
      end
   end

   // A taken last beat always leaves the frame phase or restarts its count
   a_last_in_frame: assert property (@(posedge clk) disable iff (!arst_n || soft_clear)
      out_last && consume |-> (state == st_frame) ##1 (state != st_frame || counter == 16'd1));

endmodule

/* source/framer_top.sv */
`timescale 1ns/1ps

module framer_top
#(
   parameter int FIFO_DEPTH = 16
)
(
   input  logic                clk,
   input  logic                arst_n,
   // AXI4-Lite slave
   input  logic [7:0]          awaddr,
   input  logic                awvalid,
   output logic                awready,
   input  logic [31:0]         wdata,
   input  logic [3:0]          wstrb,
   input  logic                wvalid,
   output logic                wready,
   output logic [1:0]          bresp,
   output logic                bvalid,
   input  logic                bready,
   input  logic [7:0]          araddr,
   input  logic                arvalid,
   output logic                arready,
   output logic [31:0]         rdata,
   output logic [1:0]          rresp,
   output logic                rvalid,
   input  logic                rready,
   // Sample stream
   input  logic                in_valid,
   input  framer_pkg::sample_t in_data,
   output framer_pkg::sample_t out_data,
   output logic                out_last,
   output logic                out_valid,
   input  logic                out_ready,
   output logic                eob
);

   framer_pkg::framer_cfg_t cfg;
   framer_pkg::sample_t     trg_sample;
   framer_pkg::trig_t       trg_trig;
   framer_pkg::sample_t     sample_head;
   framer_pkg::trig_t       trig_head;
   logic                    soft_clear;
   logic                    trg_push;
   logic                    sample_valid;
   logic                    trig_valid;
   logic                    pop;
   logic                    frame_done;
   logic [1:0]              overflow;   // {trig, sample}

   framer_regs i_framer_regs (
      .clk, .arst_n,
      .awaddr, .awvalid, .awready, .wdata, .wstrb, .wvalid, .wready,
      .bresp, .bvalid, .bready, .araddr, .arvalid, .arready,
      .rdata, .rresp, .rvalid, .rready,
      .frame_done, .overflow, .cfg, .soft_clear
   );

   power_trigger i_power_trigger (
      .clk, .arst_n, .soft_clear, .cfg, .in_valid, .in_data,
      .push(trg_push), .trig(trg_trig), .sample(trg_sample)
   );

   stream_fifo #(.payload_t(framer_pkg::sample_t), .DEPTH(FIFO_DEPTH)) i_sample_fifo (
      .clk, .arst_n, .soft_clear,
      .push(trg_push), .push_data(trg_sample), .pop,
      .head(sample_head), .head_valid(sample_valid), .overflow(overflow[0])
   );

   stream_fifo #(.payload_t(framer_pkg::trig_t), .DEPTH(FIFO_DEPTH)) i_trig_fifo (
      .clk, .arst_n, .soft_clear,
      .push(trg_push), .push_data(trg_trig), .pop,
      .head(trig_head), .head_valid(trig_valid), .overflow(overflow[1])
   );

   periodic_framer i_periodic_framer (
      .clk, .arst_n, .soft_clear, .cfg,
      .sample_head, .sample_valid, .trig_head, .trig_valid, .pop,
      .out_data, .out_last, .out_valid, .out_ready, .eob, .frame_done
   );

endmodule

/* verif/framer_tb.sv */
`timescale 1ns/1ps

module framer_tb;

   typedef struct packed {
      framer_pkg::sample_t data;
      logic                last;
      logic                eob;
   } beat_t;

   typedef framer_pkg::sample_t sample_q_t[$];
   typedef beat_t               beat_q_t[$];

   logic                    clk;
   logic                    arst_n;
   logic [7:0]              awaddr;
   logic                    awvalid;
   logic                    awready;
   logic [31:0]             wdata;
   logic [3:0]              wstrb;
   logic                    wvalid;
   logic                    wready;
   logic [1:0]              bresp;
   logic                    bvalid;
   logic                    bready;
   logic [7:0]              araddr;
   logic                    arvalid;
   logic                    arready;
   logic [31:0]             rdata;
   logic [1:0]              rresp;
   logic                    rvalid;
   logic                    rready;
   logic                    in_valid;
   framer_pkg::sample_t     in_data;
   framer_pkg::sample_t     out_data;
   logic                    out_last;
   logic                    out_valid;
   logic                    out_ready = 1'b1;
   logic                    eob;

   integer                  seed;
   int                      errors;
   int                      errors_at_start;
   int                      tests_run;
   int                      tests_failed;
   int                      n_frames;
   bit                      random_ready = 1'b0;
   logic [31:0]             rd;
   sample_q_t               stim;
   beat_q_t                 exp_q;
   framer_pkg::framer_cfg_t cfg_m;   // What software last wrote

   framer_top #(.FIFO_DEPTH(32)) i_framer_top (
      .clk, .arst_n,
      .awaddr, .awvalid, .awready, .wdata, .wstrb, .wvalid, .wready,
      .bresp, .bvalid, .bready, .araddr, .arvalid, .arready,
      .rdata, .rresp, .rvalid, .rready,
      .in_valid, .in_data, .out_data, .out_last, .out_valid, .out_ready, .eob
   );

   initial
   begin
      clk = 1'b0;
      forever #50 clk = ~clk;
   end

   task automatic check_value(input string name, input logic [31:0] got,
                              input logic [31:0] expected);
      if (got !== expected)
      begin
         $display("FAIL %0t ns %s got %h expected %h", $time, name, got, expected);
         errors++;
      end
   endtask

   task automatic abort_run(input string why);
      $display("Timeout: %s", why);
      $display("Some tests failed");
      $finish;
   endtask

   function automatic int magnitude(input framer_pkg::sample_t s);
      int i;
      int q;
      i = int'(s.i);
      q = int'(s.q);
      return (i < 0 ? -i : i) + (q < 0 ? -q : q);
   endfunction

   function automatic int min_one(input logic [15:0] v);
      return (v == 16'd0) ? 1 : int'(v);
   endfunction

   // Expected output beats for a stream that starts with the framer idle
   function automatic beat_q_t frame_model(input sample_q_t s,
                                           input framer_pkg::framer_cfg_t c);
      beat_q_t out;
      beat_t   b;
      int      phase;   // 0 wait, 1 offset, 2 frame, 3 gap
      int      done;
      int      frames;
      bit      first;
      bit      was_above;
      bit      above;
      phase     = 0;
      done      = 0;
      frames    = 0;
      first     = 1'b0;
      was_above = 1'b0;
      foreach (s[k])
      begin
         above = magnitude(s[k]) >= int'(c.threshold);
         case (phase)
            0:
            begin
               if (above && !was_above && c.enable)
               begin
                  phase = 1;
                  done  = 0;
               end
            end
            1:
            begin
               done++;
               if (done >= min_one(c.offset))
               begin
                  phase  = 2;
                  done   = 0;
                  first  = 1'b1;
                  frames = 0;
               end
            end
            2:
            begin
               done++;
               b.data = s[k];
               b.last = done == min_one(c.frame_len);
               b.eob  = b.last && c.max_frames != 16'd0 && frames + 1 == int'(c.max_frames);
               out.push_back(b);
               if (b.last)
               begin
                  frames++;
                  done = 0;
                  if (b.eob)
                     phase = 0;
                  else if (!(first && c.pair_first))
                     phase = 3;   // Paired first frame runs straight on
                  first = 1'b0;
               end
            end
            default:
            begin
               done++;
               if (done >= min_one(c.gap_len))
               begin
                  phase = 2;
                  done  = 0;
               end
            end
         endcase
         was_above = above;
      end
      return out;
   endfunction

   function automatic int count_lasts(input beat_q_t q);
      int n;
      n = 0;
      foreach (q[k])
         if (q[k].last)
            n++;
      return n;
   endfunction

   // Output checker
   always @(posedge clk)
   begin
      beat_t e;
      if (arst_n && out_valid && out_ready)
      begin
         if (exp_q.size() == 0)
         begin
            $display("Unexpected output beat at %0t ns", $time);
            errors++;
         end
         else
         begin
            e = exp_q.pop_front();
            check_value("out_data", 32'(out_data), 32'(e.data));
            check_value("out_last", 32'(out_last), 32'(e.last));
            check_value("eob", 32'(eob), 32'(e.eob));
         end
      end
   end

   always @(negedge clk)
   begin
      if (random_ready)
         out_ready = ($unsigned($random(seed)) % 100) < 60;   // 60% duty
      else
         out_ready = 1'b1;
   end

   task automatic axi_write(input logic [7:0] addr, input logic [31:0] data);
      int cycles;
      cycles = 0;
      @(negedge clk);
      awaddr  = addr;
      awvalid = 1'b1;
      wdata   = data;
      wstrb   = 4'hF;
      wvalid  = 1'b1;
      bready  = 1'b1;
      @(posedge clk);
      while (!awready)
      begin
         cycles++;
         if (cycles > 50)
            abort_run("AXI write was not accepted");
         @(posedge clk);
      end
      @(negedge clk);
      awvalid = 1'b0;
      wvalid  = 1'b0;
      @(posedge clk);
      while (!bvalid)
      begin
         cycles++;
         if (cycles > 50)
            abort_run("AXI write response never arrived");
         @(posedge clk);
      end
      check_value("bresp", 32'(bresp), 32'd0);   // OKAY
      @(negedge clk);
      bready = 1'b0;
   endtask

   task automatic axi_read(input logic [7:0] addr, output logic [31:0] data);
      int cycles;
      cycles = 0;
      @(negedge clk);
      araddr  = addr;
      arvalid = 1'b1;
      rready  = 1'b1;
      @(posedge clk);
      while (!arready)
      begin
         cycles++;
         if (cycles > 50)
            abort_run("AXI read address was not accepted");
         @(posedge clk);
      end
      @(negedge clk);
      arvalid = 1'b0;
      @(posedge clk);
      while (!rvalid)
      begin
         cycles++;
         if (cycles > 50)
            abort_run("AXI read data never arrived");
         @(posedge clk);
      end
      data = rdata;
      check_value("rresp", 32'(rresp), 32'd0);
      @(negedge clk);
      rready = 1'b0;
   endtask

   task automatic write_and_check(input string name, input logic [7:0] addr,
                                  input logic [31:0] value, input logic [31:0] expected);
      logic [31:0] got;
      axi_write(addr, value);
      axi_read(addr, got);
      check_value(name, got, expected);
   endtask

   // Soft clear goes out with the control write, so each run starts idle
   task automatic configure(input int frame_len, input int gap_len, input int offset,
                            input int max_frames, input bit pair);
      cfg_m            = '0;
      cfg_m.frame_len  = 16'(frame_len);
      cfg_m.gap_len    = 16'(gap_len);
      cfg_m.offset     = 16'(offset);
      cfg_m.max_frames = 16'(max_frames);
      cfg_m.threshold  = 17'd20000;
      cfg_m.pair_first = pair;
      cfg_m.enable     = 1'b1;
      axi_write(framer_pkg::reg_frame_len, 32'(frame_len));
      axi_write(framer_pkg::reg_gap_len, 32'(gap_len));
      axi_write(framer_pkg::reg_offset, 32'(offset));
      axi_write(framer_pkg::reg_max_frames, 32'(max_frames));
      axi_write(framer_pkg::reg_threshold, 32'(cfg_m.threshold));
      axi_write(framer_pkg::reg_ctrl, {1'b1, 29'd0, pair, 1'b1});
   endtask

   task automatic add_noise(input int n);
      framer_pkg::sample_t s;
      repeat (n)
      begin
         s.i = 16'($random(seed) % 1000);
         s.q = 16'($random(seed) % 1000);
         stim.push_back(s);
      end
   endtask

   // Magnitude stays above 23000
   task automatic add_level(input int n);
      framer_pkg::sample_t s;
      repeat (n)
      begin
         s.i = 16'(15000 + $random(seed) % 500);
         s.q = 16'(-9000 + $random(seed) % 500);
         stim.push_back(s);
      end
   endtask

   task automatic send_stim(input int spacing);
      foreach (stim[k])
      begin
         @(negedge clk);
         in_valid = 1'b1;
         in_data  = stim[k];
         repeat (spacing - 1)
         begin
            @(negedge clk);
            in_valid = 1'b0;
         end
      end
      @(negedge clk);
      in_valid = 1'b0;
   endtask

   task automatic wait_drain();
      int cycles;
      cycles = 0;
      while (exp_q.size() != 0)
      begin
         @(negedge clk);
         cycles++;
         if (cycles > 3000)
            abort_run("output stream stopped before all expected beats arrived");
      end
      repeat (40) @(negedge clk);   // Trailing dropped beats
   endtask

   task automatic run_stream(input int spacing);
      exp_q = frame_model(stim, cfg_m);
      n_frames = count_lasts(exp_q);
      send_stim(spacing);
      wait_drain();
   endtask

   task automatic end_test(input string name);
      tests_run++;
      if (errors != errors_at_start)
      begin
         tests_failed++;
         $display("%s: %0d errors", name, errors - errors_at_start);
      end
      else
         $display("%s: ok", name);
      errors_at_start = errors;
   endtask

   initial
   begin
      seed            = 32'h5cea_30b0;
      errors          = 0;
      errors_at_start = 0;
      tests_run       = 0;
      tests_failed    = 0;
      arst_n          = 1'b0;
      awaddr          = '0;
      awvalid         = 1'b0;
      wdata           = '0;
      wstrb           = '0;
      wvalid          = 1'b0;
      bready          = 1'b0;
      araddr          = '0;
      arvalid         = 1'b0;
      rready          = 1'b0;
      in_valid        = 1'b0;
      in_data         = '0;
      repeat (5) @(posedge clk);
      @(negedge clk);
      arst_n = 1'b1;

      axi_read(framer_pkg::reg_frames_sent, rd);
      check_value("frames_sent", rd, 32'd0);
      axi_read(framer_pkg::reg_status, rd);
      check_value("status", rd, 32'd0);
      axi_read(framer_pkg::reg_ctrl, rd);
      check_value("ctrl", rd, 32'd0);
      write_and_check("frame_len", framer_pkg::reg_frame_len, 32'hABCD_1234, 32'h0000_1234);
      write_and_check("gap_len", framer_pkg::reg_gap_len, 32'h0000_0056, 32'h0000_0056);
      write_and_check("offset", framer_pkg::reg_offset, 32'h0000_0789, 32'h0000_0789);
      write_and_check("max_frames", framer_pkg::reg_max_frames, 32'h0000_0009, 32'h0000_0009);
      write_and_check("threshold", framer_pkg::reg_threshold, 32'hFFFF_FFFF, 32'h0001_FFFF);
      write_and_check("frames_sent", framer_pkg::reg_frames_sent, 32'h1234_5678, 32'd0);
      write_and_check("unmapped", 8'h20, 32'hFFFF_FFFF, 32'd0);
      write_and_check("ctrl", framer_pkg::reg_ctrl, 32'h0000_0003, 32'h0000_0003);
      axi_write(framer_pkg::reg_ctrl, 32'd0);
      end_test("register access");

      configure(8, 2, 3, 0, 1'b0);
      stim.delete();
      add_noise(6);
      add_level(5);   // Short pulse, one crossing
      add_noise(50);
      run_stream(1);
      end_test("single pulse framing");

      configure(8, 2, 3, 0, 1'b1);
      stim.delete();
      add_noise(4);
      add_level(2);
      add_noise(45);
      run_stream(1);
      end_test("paired first frames");

      configure(8, 2, 3, 3, 1'b0);
      stim.delete();
      add_noise(5);
      add_level(40);   // Still high after the burst ends
      add_noise(10);
      add_level(3);
      add_noise(40);
      run_stream(1);
      axi_read(framer_pkg::reg_frames_sent, rd);
      check_value("frames_sent", rd, 32'd6);
      end_test("burst end after max_frames");

      configure(8, 2, 3, 0, 1'b0);
      stim.delete();
      add_noise(8);
      add_level(3);
      add_noise(70);
      random_ready = 1'b1;
      run_stream(2);
      random_ready = 1'b0;
      axi_read(framer_pkg::reg_status, rd);
      check_value("status", rd, 32'd0);
      end_test("output back-pressure");

      configure(8, 2, 3, 0, 1'b0);
      stim.delete();
      add_noise(4);
      add_level(2);
      add_noise(16);   // Stops four beats into the second frame
      run_stream(1);
      axi_read(framer_pkg::reg_frames_sent, rd);
      check_value("frames_sent", rd, 32'd1);
      axi_write(framer_pkg::reg_ctrl, 32'h8000_0001);
      axi_read(framer_pkg::reg_frames_sent, rd);
      check_value("frames_sent", rd, 32'd0);
      stim.delete();
      add_noise(6);
      add_level(2);
      add_noise(30);
      run_stream(1);
      axi_read(framer_pkg::reg_frames_sent, rd);
      check_value("frames_sent", rd, 32'(n_frames));
      end_test("soft clear mid frame");

      $display("%0d tests run, %0d failed, %0d errors", tests_run, tests_failed, errors);
      if (errors == 0)
         $display("All tests passed");
      else
         $display("Some tests failed");
      $finish;
   end

endmodule

/* sim.f */
source/framer_pkg.sv
source/framer_regs.sv
source/power_trigger.sv
source/stream_fifo.sv
source/periodic_framer.sv
source/framer_top.sv
verif/framer_tb.sv

/* Makefile */
TOP = framer_tb

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --timescale 1ns/1ps -f sim.f --top-module $(TOP)

obj_dir/$(TOP): sim.f source/*.sv verif/*.sv
	verilator --binary --timing --assert --timescale 1ns/1ps -f sim.f \
		--top-module $(TOP) --Mdir obj_dir -o $(TOP)

sim: obj_dir/$(TOP)
	./obj_dir/$(TOP) > sim.log 2>&1 || (cat sim.log; exit 1)
	cat sim.log
	! grep -q "Some tests failed" sim.log

clean:
	rm -rf obj_dir sim.log
